//--- design/laneSequencer.sv
// Lane sequencer
// Starts the MAC lanes one after another, hands each lane's partial
// sum to the next, and returns the final sum with a done pulse
`timescale 1ns/1ns

module laneSequencer (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start,
    input  sparsePkg::accT                         psumIn,
    input  logic [sparsePkg::NumLanes-1:0]         laneFinish,
    input  sparsePkg::accT [sparsePkg::NumLanes-1:0] laneSum,
    output logic [sparsePkg::NumLanes-1:0]         laneStart,
    output sparsePkg::accT                         psumLoad,
    output sparsePkg::accT                         result,
    output logic                                   done
);
    import sparsePkg::*;

    seqStateT                    seqState;
    logic [$clog2(NumLanes)-1:0] laneIdx;
    logic [$clog2(NumLanes)-1:0] nextIdx;
    logic                        lastLane;
    logic                        laneDone;
    logic                        accept;

    assign accept   = start && (seqState == SeqIdle);
    assign laneDone = (seqState == SeqRun) && laneFinish[laneIdx];
    assign lastLane = (laneIdx == NumLanes - 1);
    assign nextIdx  = laneIdx + 1'b1;
    // Done is the one cycle spent in SeqDone
    assign done     = (seqState == SeqDone);

    // ======================================================================
    // Sequencing
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seqState  <= SeqIdle;
            laneIdx   <= '0;
            laneStart <= '0;
            result    <= '0;
        end else begin
            // Start strobes are single cycle
            laneStart <= '0;
            case (seqState)
                SeqIdle: begin
                    if (accept) begin
                        laneIdx      <= '0;
                        laneStart[0] <= 1'b1;
                        seqState     <= SeqRun;
                    end
                end
                SeqRun: begin
                    if (laneDone && lastLane) begin
                        result   <= laneSum[laneIdx];
                        seqState <= SeqDone;
                    end else if (laneDone) begin
                        laneIdx            <= nextIdx;
                        laneStart[nextIdx] <= 1'b1;
                    end
                end
                SeqDone: seqState <= SeqIdle;
                default: seqState <= SeqIdle;
            endcase
        end
    end

    // Running sum, valid when the matching laneStart is high
    always_ff @(posedge clk) begin
        if (accept) begin
            psumLoad <= psumIn;
        end else if (laneDone) begin
            psumLoad <= laneSum[laneIdx];
        end
    end

    // Lanes run strictly one at a time
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(laneStart))
        else $error("laneSequencer: more than one lane started");

endmodule

//--- design/matchFinder.sv
// Match finder for one sparse MAC lane
// Picks the lowest channel flagged in both live masks and returns,
// one cycle later, its one-hot position and its packed ranks
`timescale 1ns/1ns

module matchFinder (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            search,
    input  sparsePkg::flagT actFlags,
    input  sparsePkg::flagT weiFlags,
    input  sparsePkg::flagT actFlagsOrig,
    input  sparsePkg::flagT weiFlagsOrig,
    output logic            match,
    output sparsePkg::flagT matchHot,
    output sparsePkg::chanIdxT actRank,
    output sparsePkg::chanIdxT weiRank
);
    import sparsePkg::*;

    flagT common;
    flagT lowHot;

    // Rank = count of flags strictly below the chosen channel
    function automatic chanIdxT rankBelow(flagT mask, flagT hot);
        flagT    below;
        chanIdxT cnt;
        below = mask & (hot - flagT'(1));
        cnt   = '0;
        for (int i = 0; i < ChannelDepth; i++) begin
            cnt = cnt + chanIdxT'(below[i]);
        end
        return cnt;
    endfunction

    // Channels still pending in both vectors
    assign common = actFlags & weiFlags;
    // Two's complement trick isolates the lowest set bit
    assign lowHot = common & (~common + flagT'(1));

    // Strobe only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match <= 1'b0;
        end else begin
            match <= search && (|common);
        end
    end

    // Ranks come from the original masks, not the live ones
    always_ff @(posedge clk) begin
        if (search) begin
            matchHot <= lowHot;
            actRank  <= rankBelow(actFlagsOrig, lowHot);
            weiRank  <= rankBelow(weiFlagsOrig, lowHot);
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================
    // Lane clears exactly one channel per match
    assert property (@(posedge clk) disable iff (!rst_n) match |-> $onehot(matchHot))
        else $error("matchFinder: matchHot not one-hot on match");

endmodule

//--- design/sparseMac.sv
// Zero-skipping MAC lane
// Intersects activation and weight masks for one block of channels,
// multiplies only the pairs present in both, and adds them onto the
// partial sum loaded at start; pulses laneFinish when nothing is left
`timescale 1ns/1ns

module sparseMac (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              laneStart,
    input  sparsePkg::laneInT laneIn,
    input  sparsePkg::weiVecT weiVec,
    input  sparsePkg::accT    psumLoad,
    output logic              laneFinish,
    output sparsePkg::accT    laneSum
);
    import sparsePkg::*;

    macStateT macState;
    logic     startOk;
    logic     liveEmpty;
    logic     searchQ;

    // Masks as loaded, and the copies that shrink per match
    flagT actFlagsOrig;
    flagT weiFlagsOrig;
    flagT actLive;
    flagT weiLive;

    // Match finder results
    logic    match;
    flagT    matchHot;
    chanIdxT actRank;
    chanIdxT weiRank;

    // Operand fetch
    weiAddrT                weiAddr;
    dataT                   actVal;
    dataT                   weiVal;
    logic [2*DataWidth-1:0] product;
    accT                    acc;

    // Busy lane ignores a new start
    assign startOk   = laneStart && (macState == Idle);
    assign liveEmpty = ~|(actLive & weiLive);

    // ======================================================================
    // Control
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            macState <= Idle;
        end else begin
            case (macState)
                Idle:    if (startOk) macState <= Comp;
                Comp:    if (liveEmpty) macState <= Idle;
                default: macState <= Idle;
            endcase
        end
    end

    // Live masks drop the matched channel in the accumulate cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            actLive <= '0;
            weiLive <= '0;
        end else if (startOk) begin
            actLive <= laneIn.actFlags;
            weiLive <= laneIn.weiFlags;
        end else if (match) begin
            actLive <= actLive & ~matchHot;
            weiLive <= weiLive & ~matchHot;
        end
    end

    // New search right after start and after each consumed match
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            searchQ <= 1'b0;
        end else begin
            searchQ <= startOk || match;
        end
    end

    always_ff @(posedge clk) begin
        if (startOk) begin
            actFlagsOrig <= laneIn.actFlags;
            weiFlagsOrig <= laneIn.weiFlags;
        end
    end

    // Same edge that drops to Idle, so this is a single pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            laneFinish <= 1'b0;
        end else begin
            laneFinish <= (macState == Comp) && liveEmpty;
        end
    end

    // ======================================================================
    // Datapath
    // ======================================================================
    // Weight rank is relative to this lane's base in the shared block
    assign weiAddr = laneIn.weiBase + weiAddrT'(weiRank);
    assign actVal  = laneIn.actVec[actRank];
    assign weiVal  = weiVec[weiAddr];
    assign product = actVal * weiVal;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (startOk) begin
            acc <= psumLoad;
        end else if (match) begin
            // Wraps modulo AccWidth
            acc <= acc + accT'(product);
        end
    end

    assign laneSum = acc;

    matchFinder i_match (
        .clk          (clk),
        .rst_n        (rst_n),
        .search       (searchQ),
        .actFlags     (actLive),
        .weiFlags     (weiLive),
        .actFlagsOrig (actFlagsOrig),
        .weiFlagsOrig (weiFlagsOrig),
        .match        (match),
        .matchHot     (matchHot),
        .actRank      (actRank),
        .weiRank      (weiRank)
    );

    // Sequencer never restarts a busy lane
    assert property (@(posedge clk) disable iff (!rst_n) laneStart |-> macState == Idle)
        else $error("sparseMac: laneStart while computing");

    assert property (@(posedge clk) disable iff (!rst_n) laneFinish |=> !laneFinish)
        else $error("sparseMac: laneFinish longer than one cycle");

endmodule

//--- design/sparsePe.sv
// Sparse processing element
// Three zero-skipping MAC lanes chained through a sequencer, so one
// start produces a 24-channel dot product plus the incoming partial sum
`timescale 1ns/1ns

module sparsePe (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     start,
    input  sparsePkg::accT                           psumIn,
    input  sparsePkg::laneInT [sparsePkg::NumLanes-1:0] lanes,
    input  sparsePkg::weiVecT                        weiVec,
    output sparsePkg::accT                           result,
    output logic                                     done
);
    import sparsePkg::*;

    // Per-lane handshake with the sequencer
    logic [NumLanes-1:0] laneStart;
    logic [NumLanes-1:0] laneFinish;
    accT  [NumLanes-1:0] laneSum;
    // Shared load value, only the started lane takes it
    accT                 psumLoad;

    laneSequencer i_laneSeq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .psumIn     (psumIn),
        .laneFinish (laneFinish),
        .laneSum    (laneSum),
        .laneStart  (laneStart),
        .psumLoad   (psumLoad),
        .result     (result),
        .done       (done)
    );

    // ======================================================================
    // Lanes
    // ======================================================================
    // All lanes read the same weight block at their own base
    for (genvar k = 0; k < NumLanes; k++) begin : gLane
        sparseMac i_mac (
            .clk        (clk),
            .rst_n      (rst_n),
            .laneStart  (laneStart[k]),
            .laneIn     (lanes[k]),
            .weiVec     (weiVec),
            .psumLoad   (psumLoad),
            .laneFinish (laneFinish[k]),
            .laneSum    (laneSum[k])
        );
    end

endmodule

//--- design/sparsePkg.sv
// Sparse PE shared definitions
// Widths, lane count, packed vector types, per-lane input bundle
// and the state encodings of the MAC lane and the lane sequencer
package sparsePkg;

    // ======================================================================
    // Sizes
    // ======================================================================
    localparam int DataWidth    = 8;
    localparam int ChannelDepth = 8;
    localparam int NumLanes     = 3;
    // One weight block shared by all lanes
    localparam int WeiDepth     = NumLanes * ChannelDepth;
    // Full product plus headroom for every term of the dot product
    localparam int AccWidth     = 2 * DataWidth + $clog2(WeiDepth);

    // ======================================================================
    // Types
    // ======================================================================
    typedef logic [DataWidth-1:0]            dataT;
    typedef logic [ChannelDepth-1:0]         flagT;
    typedef logic [$clog2(ChannelDepth)-1:0] chanIdxT;
    typedef logic [$clog2(WeiDepth)-1:0]     weiAddrT;
    typedef logic [AccWidth-1:0]             accT;

    // Packed values, lowest channel at index 0
    typedef dataT [ChannelDepth-1:0] actVecT;
    typedef dataT [WeiDepth-1:0]     weiVecT;

    // Everything one lane needs besides the shared weights
    typedef struct packed {
        flagT    actFlags;
        actVecT  actVec;
        flagT    weiFlags;
        weiAddrT weiBase;
    } laneInT;

    typedef enum logic {Idle, Comp} macStateT;
    typedef enum logic [1:0] {SeqIdle, SeqRun, SeqDone} seqStateT;

endpackage

//--- list.f
+incdir+tb
design/sparsePkg.sv
design/matchFinder.sv
design/sparseMac.sv
design/laneSequencer.sv
design/sparsePe.sv
tb/sparsePeTb.sv

//--- tb/sparsePeVectors.svh
// Directed cases for the sparse PE testbench
// Each entry gives three lanes, the shared weight block, the incoming
// partial sum and the hand-computed expected result

task automatic buildTable();
    // No common flag anywhere, result is the incoming sum
    addCase("allFlagsZero",
        makeLane(8'h00, 64'h0, 8'h00, 5'd0),
        makeLane(8'h00, 64'h0, 8'h00, 5'd8),
        makeLane(8'h00, 64'h0, 8'h00, 5'd16),
        {WeiDepth{8'h55}}, 21'h1ABCD, 21'h1ABCD);

    // 24 terms of 255 * 255 plus 1000, close to the accumulator top
    addCase("denseAll",
        makeLane(8'hFF, {8{8'hFF}}, 8'hFF, 5'd0),
        makeLane(8'hFF, {8{8'hFF}}, 8'hFF, 5'd8),
        makeLane(8'hFF, {8{8'hFF}}, 8'hFF, 5'd16),
        {WeiDepth{8'hFF}}, 21'd1000, 21'd1561600);

    // Lane 1 masks do not overlap
    // lane 0 gives 8 * 1 * 5, lane 2 gives 2 * 2 * 5
    addCase("disjointLane1",
        makeLane(8'hFF, {8{8'h01}}, 8'hFF, 5'd0),
        makeLane(8'h0F, {8{8'h09}}, 8'hF0, 5'd8),
        makeLane(8'h03, {8{8'h02}}, 8'h03, 5'd16),
        {WeiDepth{8'h05}}, 21'd7, 21'd67);

    // Weight i holds i+1, activation rank r holds 16+r
    // lane 0: 17*4 + 18*6 = 176
    // lane 1: 16*11 + 17*18 = 482
    // lane 2: 16*21 + 18*22 = 732
    addCase("rankedSparse",
        makeLane(8'hA6, 64'h17161514_13121110, 8'h2C, 5'd3),
        makeLane(8'h81, 64'h17161514_13121110, 8'hFF, 5'd10),
        makeLane(8'h0E, 64'h17161514_13121110, 8'h0A, 5'd20),
        192'h18171615_14131211_100F0E0D_0C0B0A09_08070605_04030201,
        21'd10, 21'd1400);
endtask

//--- tb/sparsePeTb.sv
// Sparse PE testbench
// Runs the directed table, seeded random cases against a reference
// model of the sparse dot product, and a restart during a busy run
`timescale 1ns/1ns

module sparsePeTb;
    import sparsePkg::*;

    localparam int ResetCycles = 5;
    localparam int NumRandom   = 20;
    // Worst-case cycles for one full run over all lanes
    localparam int RunCycles   = NumLanes * (2 * ChannelDepth + 4);

    typedef struct {
        string                 name;
        laneInT [NumLanes-1:0] lanes;
        weiVecT                weiVec;
        accT                   psumIn;
        accT                   expected;
    } vecCaseT;

    logic                  clk;
    logic                  rst_n;
    logic                  start;
    accT                   psumIn;
    laneInT [NumLanes-1:0] lanes;
    weiVecT                weiVec;
    accT                   result;
    logic                  done;

    vecCaseT cases[$];
    int      checkCount;
    int      errorCount;

    sparsePe i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .psumIn (psumIn),
        .lanes  (lanes),
        .weiVec (weiVec),
        .result (result),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ======================================================================
    // Table helpers
    // ======================================================================
    function automatic laneInT makeLane(flagT af, actVecT av, flagT wf, weiAddrT base);
        laneInT l;
        l.actFlags = af;
        l.actVec   = av;
        l.weiFlags = wf;
        l.weiBase  = base;
        return l;
    endfunction

    task automatic addCase(string name, laneInT l0, laneInT l1, laneInT l2,
                           weiVecT wv, accT psum, accT expected);
        vecCaseT c;
        c.name     = name;
        c.lanes    = {l2, l1, l0};
        c.weiVec   = wv;
        c.psumIn   = psum;
        c.expected = expected;
        cases.push_back(c);
    endtask

    `include "sparsePeVectors.svh"

    // Reference model, walks the channels and counts ranks on the way
    function automatic accT refResult(laneInT [NumLanes-1:0] laneSet, weiVecT wv, accT psum);
        accT sum;
        int  aRank;
        int  wRank;
        int  prod;
        sum = psum;
        for (int k = 0; k < NumLanes; k++) begin
            aRank = 0;
            wRank = 0;
            for (int c = 0; c < ChannelDepth; c++) begin
                if (laneSet[k].actFlags[c] && laneSet[k].weiFlags[c]) begin
                    prod = int'(laneSet[k].actVec[aRank]) *
                           int'(wv[int'(laneSet[k].weiBase) + wRank]);
                    sum  = sum + accT'(prod);
                end
                if (laneSet[k].actFlags[c]) aRank++;
                if (laneSet[k].weiFlags[c]) wRank++;
            end
        end
        return sum;
    endfunction

    // ======================================================================
    // Compare tasks
    // ======================================================================
    task automatic checkAcc(string name, accT expected, accT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic checkPulse(string name, logic expected, logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s: done expected %b, actual %b", name, expected, actual);
        end
    endtask

    // One run, optionally with a second start while busy
    task automatic runCase(string name, laneInT [NumLanes-1:0] laneSet, weiVecT wv,
                           accT psum, accT expected, bit restartBusy);
        @(posedge clk);
        lanes  <= laneSet;
        weiVec <= wv;
        psumIn <= psum;
        start  <= 1'b1;
        @(posedge clk);
        start  <= 1'b0;
        if (restartBusy) begin
            repeat (3) @(posedge clk);
            // Second start carries another partial sum, so taking it would show
            start  <= 1'b1;
            psumIn <= ~psum;
            @(posedge clk);
            start  <= 1'b0;
            psumIn <= psum;
        end
        // Outputs sampled mid-cycle
        do @(negedge clk); while (done !== 1'b1);
        checkAcc(name, expected, result);
        @(negedge clk);
        checkPulse(name, 1'b0, done);
        // Ignored start must not give a second done
        if (restartBusy) begin
            repeat (RunCycles) begin
                @(negedge clk);
                checkPulse(name, 1'b0, done);
            end
            checkAcc(name, expected, result);
        end
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        laneInT [NumLanes-1:0] rndLanes;
        weiVecT                rndWei;
        accT                   rndPsum;
        int                    pop;

        checkCount = 0;
        errorCount = 0;
        rst_n  = 1'b0;
        start  = 1'b0;
        psumIn = '0;
        lanes  = '0;
        weiVec = '0;
        void'($urandom(6906));
        buildTable();

        repeat (ResetCycles) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checkAcc("reset", '0, result);
        checkPulse("reset", 1'b0, done);

        foreach (cases[i]) begin
            runCase(cases[i].name, cases[i].lanes, cases[i].weiVec,
                    cases[i].psumIn, cases[i].expected, 1'b0);
        end

        for (int n = 0; n < NumRandom; n++) begin
            for (int k = 0; k < NumLanes; k++) begin
                rndLanes[k].actFlags = flagT'($urandom);
                rndLanes[k].weiFlags = flagT'($urandom);
                for (int j = 0; j < ChannelDepth; j++) begin
                    rndLanes[k].actVec[j] = dataT'($urandom);
                end
                // Keep the packed weights inside the block
                pop = $countones(rndLanes[k].weiFlags);
                rndLanes[k].weiBase = weiAddrT'($urandom % (WeiDepth - pop + 1));
            end
            for (int j = 0; j < WeiDepth; j++) begin
                rndWei[j] = dataT'($urandom);
            end
            rndPsum = accT'($urandom);
            runCase($sformatf("random%0d", n), rndLanes, rndWei, rndPsum,
                    refResult(rndLanes, rndWei, rndPsum), 1'b0);
        end

        // Dense case again, long enough to restart in the middle
        runCase("busyRestart", cases[1].lanes, cases[1].weiVec,
                cases[1].psumIn, cases[1].expected, 1'b1);

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Budget grows with the number of cases
    initial begin : watchdog
        int limit;
        #1;
        limit = (cases.size() + NumRandom + 2) * RunCycles + ResetCycles + 200;
        repeat (limit) @(posedge clk);
        $display("Watchdog: the run did not finish within %0d cycles, the DUT seems hung",
                 limit);
        $display("Done: errors found");
        $finish;
    end

endmodule
